//--- Bender.yml
package:
  name: lsu_subsystem

sources:
  - common/core_types_pkg.sv
  - common/mem_ops_pkg.sv
  - lsu/lsu_addr_gen.sv
  - lsu/lsu_req_reg.sv
  - lsu/lsu_unit.sv
  - dmem/lane_scratchpad.sv
  - src/lsu_subsystem_top.sv
  - target: test
    files:
      - tests/tb_lsu_subsystem.sv

//--- common/core_types_pkg.sv
`default_nettype none

// types shared along the core pipeline
package core_types_pkg;

	// warps resident in the core
	localparam int NUM_WARPS = 4;
	// bits needed to name one warp
	localparam int WARP_W = $clog2(NUM_WARPS);

	// architectural registers per thread
	localparam int NUM_REGS = 32;
	// register index width
	localparam int REG_W = $clog2(NUM_REGS);

	// warp number carried with every instruction
	typedef logic [WARP_W-1:0] warp_id_t;

	// destination register index
	typedef logic [REG_W-1:0] reg_addr_t;

	// writeback source select
	// the load/store path only carries this along
	typedef enum logic [1:0] {
		// nothing written back
		WB_NONE = 2'd0,
		// result from the alu
		WB_ALU  = 2'd1,
		// result from data memory
		WB_MEM  = 2'd2,
		// return address of a jump
		WB_JAL  = 2'd3
	} wb_code_e;

endpackage

`default_nettype wire

//--- common/mem_ops_pkg.sv
`default_nettype none

// types describing memory operations
package mem_ops_pkg;

	// byte address and data word width
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// low address bits that pick a byte inside a word
	localparam int BYTE_OFF_W = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// load opcodes, the U forms zero extend
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_op_e;

	// store opcodes
	typedef enum logic [2:0] {
		ST_NONE = 3'd0,
		// byte
		ST_SB   = 3'd1,
		// halfword
		ST_SH   = 3'd2,
		// full word
		ST_SW   = 3'd3
	} store_op_e;

endpackage

`default_nettype wire

//--- dmem/lane_scratchpad.sv
`timescale 1ns/1ps
`default_nettype none

// one scratchpad bank per lane plus the load writeback register
module lane_scratchpad
	import core_types_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int NUM_LANES  = 4,
	parameter int BANK_WORDS = 64
) (
	input  wire                        clk,
	input  wire                        arst_n,

	// request from the load/store unit
	input  wire  [NUM_LANES-1:0]       mem_valid,
	input  wire addr_t [NUM_LANES-1:0] mem_addr,
	input  wire data_t [NUM_LANES-1:0] mem_store_data,
	input  wire load_op_e              mem_load_op,
	input  wire store_op_e             mem_store_op,
	input  wire reg_addr_t             mem_rd,
	input  wire warp_id_t              mem_warp,
	input  wire wb_code_e              mem_wb,

	// register file has no write port free
	input  wire                        no_wb_slot,

	// load writeback
	output logic [NUM_LANES-1:0]       wb_valid,
	output data_t [NUM_LANES-1:0]      wb_data,
	output reg_addr_t                  wb_rd,
	output warp_id_t                   wb_warp,
	output wb_code_e                   wb_code,

	// result held and blocked, stalls the request stage
	output logic                       delay
);

	// word index width, at least one bit
	localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

	// lane banks
	data_t bank [NUM_LANES][BANK_WORDS];

	// word picked in each bank and its current contents
	logic [IDX_W-1:0] word_idx [NUM_LANES];
	data_t            rd_word  [NUM_LANES];

	// bank and holding register move together
	logic advance;
	logic is_store;
	logic is_load;

	// merge a byte or halfword into the old word
	// offset bits pick the byte lane, halfwords ignore bit 0
	function automatic data_t merge_store(input data_t old_word, input data_t wdata,
			input store_op_e op, input logic [BYTE_OFF_W-1:0] off);
		data_t new_word;
		new_word = old_word;
		case (op)
			ST_SB: new_word[{off, 3'b000} +: 8] = wdata[7:0];
			ST_SH: new_word[{off[1], 4'b0000} +: 16] = wdata[15:0];
			ST_SW: new_word = wdata;
			default: new_word = old_word;
		endcase
		return new_word;
	endfunction

	// pick a byte or halfword and extend it
	function automatic data_t load_extend(input data_t word, input load_op_e op,
			input logic [BYTE_OFF_W-1:0] off);
		logic [7:0]  byte_val;
		logic [15:0] half_val;
		data_t       result;
		byte_val = word[{off, 3'b000} +: 8];
		half_val = word[{off[1], 4'b0000} +: 16];
		case (op)
			LD_LB:   result = {{(DATA_W-8){byte_val[7]}}, byte_val};
			LD_LBU:  result = {{(DATA_W-8){1'b0}}, byte_val};
			LD_LH:   result = {{(DATA_W-16){half_val[15]}}, half_val};
			LD_LHU:  result = {{(DATA_W-16){1'b0}}, half_val};
			LD_LW:   result = word;
			default: result = '0;
		endcase
		return result;
	endfunction

	// stall only while a held result cannot leave
	assign delay    = (|wb_valid) && no_wb_slot;
	// holding register empty or being consumed this edge
	assign advance  = !delay;
	assign is_store = (mem_store_op != ST_NONE);
	assign is_load  = (mem_load_op != LD_NONE);

	// word index is the address above the byte offset, wrapped to the bank
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			word_idx[l] = IDX_W'((mem_addr[l] >> BYTE_OFF_W) % BANK_WORDS);
			rd_word[l]  = bank[l][word_idx[l]];
		end
	end

	// bank writes, read-modify-write of the addressed word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				for (int w = 0; w < BANK_WORDS; w++) begin
					bank[l][w] <= '0;
				end
			end
		end else if (advance && is_store) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				// masked lanes keep their word
				if (mem_valid[l]) begin
					bank[l][word_idx[l]] <= merge_store(rd_word[l], mem_store_data[l],
						mem_store_op, mem_addr[l][BYTE_OFF_W-1:0]);
				end
			end
		end
	end

	// holding register mask
	// stores and bubbles leave it empty
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= '0;
		end else if (advance) begin
			wb_valid <= is_load ? mem_valid : '0;
		end
	end

	// holding register payload
	always_ff @(posedge clk) begin
		if (advance) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				wb_data[l] <= load_extend(rd_word[l], mem_load_op,
					mem_addr[l][BYTE_OFF_W-1:0]);
			end
			wb_rd   <= mem_rd;
			wb_warp <= mem_warp;
			wb_code <= mem_wb;
		end
	end

endmodule

`default_nettype wire

//--- lsu/lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

// effective address per lane
module lsu_addr_gen
	import mem_ops_pkg::*;
#(
	parameter int NUM_LANES = 4
) (
	// base register value of each thread
	input  wire addr_t [NUM_LANES-1:0] base,
	// immediate or register offset of each thread
	input  wire addr_t [NUM_LANES-1:0] offset,
	// base plus offset
	output addr_t      [NUM_LANES-1:0] addr
);

	// one adder per lane, all in parallel
	// inactive lanes still add, the mask drops them further on
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			// wraps at 32 bits like the integer datapath
			addr[l] = base[l] + offset[l];
		end
	end

endmodule

`default_nettype wire

//--- lsu/lsu_req_reg.sv
`timescale 1ns/1ps
`default_nettype none

// one warp request, held while memory stalls
module lsu_req_reg
	import core_types_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int NUM_LANES = 4
) (
	input  wire                        clk,
	input  wire                        arst_n,
	// memory cannot take the request this cycle
	input  wire                        stall,

	input  wire  [NUM_LANES-1:0]       in_valid,
	input  wire addr_t [NUM_LANES-1:0] in_addr,
	input  wire data_t [NUM_LANES-1:0] in_store_data,
	input  wire load_op_e              in_load_op,
	input  wire store_op_e             in_store_op,
	input  wire reg_addr_t             in_rd,
	input  wire warp_id_t              in_warp,
	input  wire wb_code_e              in_wb,

	output logic [NUM_LANES-1:0]       out_valid,
	output addr_t [NUM_LANES-1:0]      out_addr,
	output data_t [NUM_LANES-1:0]      out_store_data,
	output load_op_e                   out_load_op,
	output store_op_e                  out_store_op,
	output reg_addr_t                  out_rd,
	output warp_id_t                   out_warp,
	output wb_code_e                   out_wb
);

	// mask and opcodes, cleared so an empty slot does nothing downstream
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid    <= '0;
			out_load_op  <= LD_NONE;
			out_store_op <= ST_NONE;
		end else if (!stall) begin
			// a zero input mask loads a bubble
			out_valid    <= in_valid;
			out_load_op  <= in_load_op;
			out_store_op <= in_store_op;
		end
	end

	// payload fields, only meaningful under a set mask
	always_ff @(posedge clk) begin
		if (!stall) begin
			out_addr       <= in_addr;
			out_store_data <= in_store_data;
			out_rd         <= in_rd;
			out_warp       <= in_warp;
			out_wb         <= in_wb;
		end
	end

endmodule

`default_nettype wire

//--- lsu/lsu_unit.sv
`timescale 1ns/1ps
`default_nettype none

// load/store unit, address add then one request stage
module lsu_unit
	import core_types_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int NUM_LANES = 4
) (
	input  wire                        clk,
	input  wire                        arst_n,

	// warp request from issue
	input  wire  [NUM_LANES-1:0]       req_valid,
	input  wire addr_t [NUM_LANES-1:0] req_base,
	input  wire addr_t [NUM_LANES-1:0] req_offset,
	input  wire data_t [NUM_LANES-1:0] req_store_data,
	input  wire load_op_e              req_load_op,
	input  wire store_op_e             req_store_op,
	input  wire reg_addr_t             req_rd,
	input  wire warp_id_t              req_warp,
	input  wire wb_code_e              req_wb,

	// memory is holding a blocked result
	input  wire                        delay,

	// request towards the scratchpad
	output logic [NUM_LANES-1:0]       mem_valid,
	output addr_t [NUM_LANES-1:0]      mem_addr,
	output data_t [NUM_LANES-1:0]      mem_store_data,
	output load_op_e                   mem_load_op,
	output store_op_e                  mem_store_op,
	output reg_addr_t                  mem_rd,
	output warp_id_t                   mem_warp,
	output wb_code_e                   mem_wb
);

	// per-lane byte address before the register
	addr_t [NUM_LANES-1:0] lane_addr;

	lsu_addr_gen #(
		.NUM_LANES (NUM_LANES)
	) i_lsu_addr_gen (
		.base   (req_base),
		.offset (req_offset),
		.addr   (lane_addr)
	);

	// request buffer
	// stalls on the memory delay, so the requester sees delay as not accepted
	lsu_req_reg #(
		.NUM_LANES (NUM_LANES)
	) i_lsu_req_reg (
		.clk            (clk),
		.arst_n         (arst_n),
		.stall          (delay),
		.in_valid       (req_valid),
		.in_addr        (lane_addr),
		.in_store_data  (req_store_data),
		.in_load_op     (req_load_op),
		.in_store_op    (req_store_op),
		.in_rd          (req_rd),
		.in_warp        (req_warp),
		.in_wb          (req_wb),
		.out_valid      (mem_valid),
		.out_addr       (mem_addr),
		.out_store_data (mem_store_data),
		.out_load_op    (mem_load_op),
		.out_store_op   (mem_store_op),
		.out_rd         (mem_rd),
		.out_warp       (mem_warp),
		.out_wb         (mem_wb)
	);

endmodule

`default_nettype wire

//--- lsu_subsystem.f
common/core_types_pkg.sv
common/mem_ops_pkg.sv
lsu/lsu_addr_gen.sv
lsu/lsu_req_reg.sv
lsu/lsu_unit.sv
dmem/lane_scratchpad.sv
src/lsu_subsystem_top.sv
tests/tb_lsu_subsystem.sv

//--- src/lsu_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

// load/store path, unit in front of the lane scratchpad
module lsu_subsystem_top
	import core_types_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int NUM_LANES  = 4,
	parameter int BANK_WORDS = 64
) (
	input  wire                        clk,
	input  wire                        arst_n,

	// warp memory instruction
	input  wire  [NUM_LANES-1:0]       req_valid,
	input  wire addr_t [NUM_LANES-1:0] req_base,
	input  wire addr_t [NUM_LANES-1:0] req_offset,
	input  wire data_t [NUM_LANES-1:0] req_store_data,
	input  wire load_op_e              req_load_op,
	input  wire store_op_e             req_store_op,
	input  wire reg_addr_t             req_rd,
	input  wire warp_id_t              req_warp,
	input  wire wb_code_e              req_wb,

	// back-pressure from the register file
	input  wire                        no_wb_slot,

	output logic [NUM_LANES-1:0]       wb_valid,
	output data_t [NUM_LANES-1:0]      wb_data,
	output reg_addr_t                  wb_rd,
	output warp_id_t                   wb_warp,
	output wb_code_e                   wb_code,
	// request not taken while high
	output logic                       delay
);

	// request bundle between unit and memory
	logic [NUM_LANES-1:0]  mem_valid;
	addr_t [NUM_LANES-1:0] mem_addr;
	data_t [NUM_LANES-1:0] mem_store_data;
	load_op_e              mem_load_op;
	store_op_e             mem_store_op;
	reg_addr_t             mem_rd;
	warp_id_t              mem_warp;
	wb_code_e              mem_wb;

	lsu_unit #(
		.NUM_LANES (NUM_LANES)
	) i_lsu_unit (
		.clk            (clk),
		.arst_n         (arst_n),
		.req_valid      (req_valid),
		.req_base       (req_base),
		.req_offset     (req_offset),
		.req_store_data (req_store_data),
		.req_load_op    (req_load_op),
		.req_store_op   (req_store_op),
		.req_rd         (req_rd),
		.req_warp       (req_warp),
		.req_wb         (req_wb),
		.delay          (delay),
		.mem_valid      (mem_valid),
		.mem_addr       (mem_addr),
		.mem_store_data (mem_store_data),
		.mem_load_op    (mem_load_op),
		.mem_store_op   (mem_store_op),
		.mem_rd         (mem_rd),
		.mem_warp       (mem_warp),
		.mem_wb         (mem_wb)
	);

	// delay comes back from here
	lane_scratchpad #(
		.NUM_LANES  (NUM_LANES),
		.BANK_WORDS (BANK_WORDS)
	) i_lane_scratchpad (
		.clk            (clk),
		.arst_n         (arst_n),
		.mem_valid      (mem_valid),
		.mem_addr       (mem_addr),
		.mem_store_data (mem_store_data),
		.mem_load_op    (mem_load_op),
		.mem_store_op   (mem_store_op),
		.mem_rd         (mem_rd),
		.mem_warp       (mem_warp),
		.mem_wb         (mem_wb),
		.no_wb_slot     (no_wb_slot),
		.wb_valid       (wb_valid),
		.wb_data        (wb_data),
		.wb_rd          (wb_rd),
		.wb_warp        (wb_warp),
		.wb_code        (wb_code),
		.delay          (delay)
	);

endmodule

`default_nettype wire

//--- tests/tb_lsu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_subsystem
	import core_types_pkg::*;
	import mem_ops_pkg::*;
();

	localparam int NUM_LANES    = 4;
	localparam int BANK_WORDS   = 64;
	localparam int RESET_CYCLES = 8;
	// requests issued over all tests: 4 + 24 + 48 + 96 + 40 + 300
	localparam int TOTAL_REQ    = 512;

	logic clk;
	logic arst_n;
	logic no_wb_slot = 1'b0;
	logic  [NUM_LANES-1:0] req_valid;
	addr_t [NUM_LANES-1:0] req_base, req_offset;
	data_t [NUM_LANES-1:0] req_store_data;
	load_op_e  req_load_op;
	store_op_e req_store_op;
	reg_addr_t req_rd;
	warp_id_t  req_warp;
	wb_code_e  req_wb;
	logic  [NUM_LANES-1:0] wb_valid;
	data_t [NUM_LANES-1:0] wb_data;
	reg_addr_t wb_rd;
	warp_id_t  wb_warp;
	wb_code_e  wb_code;
	logic      delay;

	// per-lane fields for the next request
	addr_t [NUM_LANES-1:0] lane_base, lane_off;
	data_t [NUM_LANES-1:0] lane_wdata;

	// model banks and the expected writebacks in order
	data_t model [NUM_LANES][BANK_WORDS];
	logic [NUM_LANES-1:0]    exp_mask_q [$];
	logic [NUM_LANES*32-1:0] exp_data_q [$];
	logic [8:0]              exp_meta_q [$];
	int                      exp_cyc_q  [$];

	// load occupancy of the request stage and the holding stage
	logic reg_has_load = 1'b0;
	logic hold_has_load = 1'b0;

	int    cycle = 0;
	int    errors = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    test_err_start;
	int    bp_left = 0;
	logic  bp_on = 1'b0;
	logic  strict_lat = 1'b1;
	string cur_test = "none";
	load_op_e ld_ops [5] = '{LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW};

	lsu_subsystem_top #(
		.NUM_LANES  (NUM_LANES),
		.BANK_WORDS (BANK_WORDS)
	) i_lsu_subsystem_top (
		.clk (clk), .arst_n (arst_n),
		.req_valid (req_valid), .req_base (req_base), .req_offset (req_offset),
		.req_store_data (req_store_data), .req_load_op (req_load_op),
		.req_store_op (req_store_op), .req_rd (req_rd), .req_warp (req_warp),
		.req_wb (req_wb), .no_wb_slot (no_wb_slot),
		.wb_valid (wb_valid), .wb_data (wb_data), .wb_rd (wb_rd),
		.wb_warp (wb_warp), .wb_code (wb_code), .delay (delay)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// edge index, read before the update at each posedge
	always @(posedge clk) cycle <= cycle + 1;

	// random stretches of register file back-pressure
	always @(negedge clk) begin
		if (!bp_on) begin
			no_wb_slot <= 1'b0;
			bp_left = 0;
		end else if (bp_left == 0) begin
			no_wb_slot <= 1'($urandom_range(0, 1));
			bp_left = $urandom_range(1, 5);
		end else begin
			bp_left = bp_left - 1;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		errors++;
		$display("FAIL %s: %s expected %h actual %h", cur_test, what, exp_val, act_val);
	endtask

	// expected load value from the model banks
	function automatic data_t ref_load(input int lane, input addr_t a, input load_op_e op);
		data_t w;
		data_t b;
		data_t h;
		w = model[lane][(a >> 2) % BANK_WORDS];
		b = (w >> (8 * a[1:0])) & 32'h0000_00ff;
		h = (w >> (16 * a[1])) & 32'h0000_ffff;
		case (op)
			LD_LB:   return b[7] ? (b | 32'hffff_ff00) : b;
			LD_LBU:  return b;
			LD_LH:   return h[15] ? (h | 32'hffff_0000) : h;
			LD_LHU:  return h;
			LD_LW:   return w;
			default: return '0;
		endcase
	endfunction

	task automatic store_model(input int lane, input addr_t a, input data_t d,
			input store_op_e op);
		int    idx;
		int    sh;
		data_t m;
		idx = (a >> 2) % BANK_WORDS;
		sh  = (op == ST_SB) ? 8 * a[1:0] : (op == ST_SH) ? 16 * a[1] : 0;
		m   = (op == ST_SB) ? 32'hff << sh : (op == ST_SH) ? 32'hffff << sh : '1;
		model[lane][idx] = (model[lane][idx] & ~m) | ((d << sh) & m);
	endtask

	// drive one request on the falling edge, repeat until delay lets it in
	task automatic issue(input logic [NUM_LANES-1:0] mask, input load_op_e ld,
			input store_op_e st, input reg_addr_t rd, input warp_id_t wp, input wb_code_e wb);
		logic [NUM_LANES*32-1:0] e_data;
		logic                    accepted;
		addr_t                   a;
		@(negedge clk);
		req_valid = mask;
		req_base = lane_base;
		req_offset = lane_off;
		req_store_data = lane_wdata;
		req_load_op = ld;
		req_store_op = st;
		req_rd = rd;
		req_warp = wp;
		req_wb = wb;
		accepted = 1'b0;
		e_data = '0;
		while (!accepted) begin
			#1;
			accepted = !delay;
			if (accepted) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					a = lane_base[l] + lane_off[l];
					if (mask[l] && st != ST_NONE) store_model(l, a, lane_wdata[l], st);
					if (mask[l] && ld != LD_NONE) e_data[l*32 +: 32] = ref_load(l, a, ld);
				end
				if (ld != LD_NONE) begin
					exp_mask_q.push_back(mask);
					exp_data_q.push_back(e_data);
					exp_meta_q.push_back({rd, wp, wb});
					exp_cyc_q.push_back(cycle);
				end
			end
			@(posedge clk);
			if (!accepted) @(negedge clk);
		end
	endtask

	task automatic random_lanes(input logic full_addr);
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_base[l]  = full_addr ? $urandom : $urandom_range(0, 1023);
			lane_off[l]   = full_addr ? $urandom : $urandom_range(0, 255);
			lane_wdata[l] = $urandom;
		end
	endtask

	function automatic logic [NUM_LANES-1:0] rand_mask();
		logic [NUM_LANES-1:0] m;
		m = NUM_LANES'($urandom);
		return (m == '0) ? NUM_LANES'(1) : m;
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		test_err_start = errors;
	endtask

	// let outstanding loads drain, then print the test line
	task automatic finish_test();
		int waited;
		@(negedge clk);
		req_valid = '0;
		req_load_op = LD_NONE;
		req_store_op = ST_NONE;
		waited = 0;
		while (exp_mask_q.size() != 0 && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		if (exp_mask_q.size() != 0) begin
			errors++;
			$display("%s: %0d loads were never written back", cur_test, exp_mask_q.size());
			exp_mask_q.delete();
			exp_data_q.delete();
			exp_meta_q.delete();
			exp_cyc_q.delete();
		end
		tests_run++;
		if (errors != test_err_start) tests_failed++;
		$display("test %s done, %0d errors", cur_test, errors - test_err_start);
	endtask

	// compares every consumed writeback with the head of the queue
	always @(posedge clk) begin
		logic [NUM_LANES-1:0]    e_mask;
		logic [NUM_LANES*32-1:0] e_data;
		logic [8:0]              e_meta;
		int                      e_cyc;
		logic                    e_delay;
		if (arst_n && (|wb_valid) && !no_wb_slot) begin
			if (exp_mask_q.size() == 0) begin
				errors++;
				$display("%s: writeback seen with no load outstanding", cur_test);
			end else begin
				e_mask = exp_mask_q.pop_front();
				e_data = exp_data_q.pop_front();
				e_meta = exp_meta_q.pop_front();
				e_cyc  = exp_cyc_q.pop_front();
				if (wb_valid !== e_mask) report_mismatch("mask", e_mask, wb_valid);
				for (int l = 0; l < NUM_LANES; l++) begin
					if (e_mask[l] && wb_data[l] !== e_data[l*32 +: 32])
						report_mismatch($sformatf("lane %0d data", l), e_data[l*32 +: 32],
							wb_data[l]);
				end
				if (wb_rd !== e_meta[8:4]) report_mismatch("rd", e_meta[8:4], wb_rd);
				if (wb_warp !== e_meta[3:2]) report_mismatch("warp", e_meta[3:2], wb_warp);
				if (wb_code !== e_meta[1:0]) report_mismatch("code", e_meta[1:0], wb_code);
				if (strict_lat && cycle - e_cyc != 2)
					report_mismatch("latency", 2, cycle - e_cyc);
			end
		end
		// stall expected only with a modelled load result waiting and the slot refused
		e_delay = hold_has_load && no_wb_slot;
		if (arst_n && delay !== e_delay)
			report_mismatch("delay", e_delay, delay);
		// both stages step on the edge, frozen while stalled
		if (!arst_n) begin
			reg_has_load  = 1'b0;
			hold_has_load = 1'b0;
		end else if (!e_delay) begin
			hold_has_load = reg_has_load;
			reg_has_load  = (|req_valid) && (req_load_op != LD_NONE);
		end
	end

	initial begin
		void'($urandom(65360));
		foreach (model[l, w]) model[l][w] = '0;
		arst_n = 1'b0;
		req_valid = '0;
		req_base = '0;
		req_offset = '0;
		req_store_data = '0;
		req_load_op = LD_NONE;
		req_store_op = ST_NONE;
		req_rd = '0;
		req_warp = '0;
		req_wb = WB_NONE;
		lane_base = '0;
		lane_off = '0;
		lane_wdata = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		start_test("reset_state");
		if (wb_valid !== '0) report_mismatch("wb_valid", 0, wb_valid);
		if (delay !== 1'b0) report_mismatch("delay", 0, delay);
		for (int i = 0; i < 4; i++) begin
			random_lanes(1'b1);
			issue('1, LD_LW, ST_NONE, 5'(i), 2'(i), WB_MEM);
		end
		finish_test();

		start_test("word_store_load");
		// full mask first, then a random mask over the same words
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 8; i++) begin
				random_lanes(1'b0);
				lane_base = '0;
				for (int l = 0; l < NUM_LANES; l++) lane_off[l] = 4 * i;
				issue(p == 0 ? '1 : rand_mask(), LD_NONE, ST_SW, '0, '0, WB_NONE);
			end
		end
		for (int i = 0; i < 8; i++) begin
			for (int l = 0; l < NUM_LANES; l++) lane_off[l] = 4 * i;
			issue('1, LD_LW, ST_NONE, 5'(i), 2'(i), WB_MEM);
		end
		finish_test();

		start_test("subword_access");
		for (int off = 0; off < 4; off++) begin
			for (int s = 0; s < 2; s++) begin
				random_lanes(1'b0);
				for (int l = 0; l < NUM_LANES; l++) begin
					lane_base[l] = 4 * (16 + l);
					lane_off[l]  = off;
				end
				issue('1, LD_NONE, s == 0 ? ST_SB : ST_SH, '0, '0, WB_NONE);
				for (int k = 0; k < 5; k++)
					issue('1, ld_ops[k], ST_NONE, 5'(k), 2'(off), WB_MEM);
			end
		end
		finish_test();

		start_test("address_generation");
		for (int w = 0; w < BANK_WORDS; w++) begin
			random_lanes(1'b0);
			lane_base = '0;
			for (int l = 0; l < NUM_LANES; l++) lane_off[l] = 4 * w;
			issue('1, LD_NONE, ST_SW, '0, '0, WB_NONE);
		end
		for (int i = 0; i < 32; i++) begin
			random_lanes(1'b1);
			issue('1, LD_LW, ST_NONE, 5'($urandom), 2'($urandom), WB_MEM);
		end
		finish_test();

		start_test("back_pressure");
		strict_lat = 1'b0;
		bp_on = 1'b1;
		for (int i = 0; i < 40; i++) begin
			random_lanes(1'b1);
			issue(rand_mask(), load_op_e'($urandom_range(1, 5)), ST_NONE, 5'($urandom),
				2'($urandom), wb_code_e'($urandom_range(0, 3)));
		end
		finish_test();

		start_test("random_mix");
		for (int i = 0; i < 300; i++) begin
			random_lanes(1'b0);
			if ($urandom_range(0, 1))
				issue(rand_mask(), LD_NONE, store_op_e'($urandom_range(1, 3)), '0, '0, WB_NONE);
			else
				issue(rand_mask(), load_op_e'($urandom_range(1, 5)), ST_NONE, 5'($urandom),
					2'($urandom), wb_code_e'($urandom_range(0, 3)));
		end
		finish_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// run length bound from the request count
	initial begin
		repeat (RESET_CYCLES + 40 * TOTAL_REQ) @(posedge clk);
		if (delay)
			$display("timeout in %s: delay stayed high, the writeback stall never cleared",
				cur_test);
		else
			$display("timeout in %s: the run did not finish in time", cur_test);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
